//--- Makefile
# Verilator build and run of the arcade board testbench
TOP := arcade_board_tb
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
		--top-module $(TOP) -f arcade_board.f

run: compile
	./obj_dir/V$(TOP) +verilator+error+limit+1000 > $(LOG); cat $(LOG)
	@if grep -qF "*** TEST FAILED ***" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -qF "*** TEST PASSED ***" $(LOG) || (echo "Simulation did not finish"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

//--- arcade_board.f
rtl/game_pkg.sv
rtl/mem_pkg.sv
rtl/rom_download_fsm.sv
rtl/reset_hold_timer.sv
rtl/rom_store.sv
rtl/control_mapper.sv
rtl/arcade_board_top.sv
verification/arcade_board_asserts.sv
verification/arcade_board_tb.sv

//--- rtl/arcade_board_top.sv
// Arcade board glue top level
// Download FSM, reset hold timer, ROM store and control mapper
`default_nettype none

module arcade_board_top #(
	parameter int RESET_HOLD = 16,
	parameter int ROM_AW     = mem_pkg::ROM_AW
) (
	input  wire                           clk_sys,
	input  wire                           reset,
	input  wire                           dl_active,
	input  wire                           dl_wr,
	input  wire  [ROM_AW-1:0]             dl_addr,
	input  wire  [7:0]                    dl_data,
	input  wire                           user_reset,
	input  wire  [ROM_AW-1:0]             main_addr,
	input  wire  [mem_pkg::SND_AW-1:0]    snd_addr,
	input  game_pkg::game_kind            game_sel,
	input  wire                           swap,
	input  wire  [game_pkg::PLAYER_W-1:0] p1,
	input  wire  [game_pkg::PLAYER_W-1:0] p2,
	input  wire                           coin1,
	input  wire                           coin2,
	input  wire                           start1,
	input  wire                           start2,
	output logic                          core_reset,
	output logic                          loaded,
	output logic [7:0]                    main_data,
	output logic [7:0]                    snd_data,
	output logic [game_pkg::JOY_W-1:0]    ja,
	output logic [game_pkg::JOY_W-1:0]    jb,
	output logic [game_pkg::BTN_W-1:0]    btn
);

	logic hold_start;
	logic hold_done;

	rom_download_fsm #(.RESET_HOLD(RESET_HOLD)) u_dl_fsm (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.dl_active  (dl_active),
		.user_reset (user_reset),
		.hold_done  (hold_done),
		.hold_start (hold_start),
		.core_reset (core_reset),
		.loaded     (loaded)
	);

	reset_hold_timer #(.RESET_HOLD(RESET_HOLD)) u_hold (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.hold_start (hold_start),
		.hold_done  (hold_done)
	);

	rom_store #(.ROM_AW(ROM_AW)) u_rom (
		.clk_sys   (clk_sys),
		.dl_wr     (dl_wr),
		.dl_addr   (dl_addr),
		.dl_data   (dl_data),
		.main_addr (main_addr),
		.snd_addr  (snd_addr),
		.main_data (main_data),
		.snd_data  (snd_data)
	);

	control_mapper u_ctrl (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.game_sel   (game_sel),
		.swap       (swap),
		.p1         (p1),
		.p2         (p2),
		.coin1      (coin1),
		.coin2      (coin2),
		.start1     (start1),
		.start2     (start2),
		.core_reset (core_reset),
		.ja         (ja),
		.jb         (jb),
		.btn        (btn)
	);

endmodule

`default_nettype wire

//--- rtl/control_mapper.sv
// Player controls to game core joystick and button words
// Per-game layouts, player swap and Sinistar direction latches
`default_nettype none

module control_mapper (
	input  wire                           clk_sys,
	input  wire                           reset,
	input  game_pkg::game_kind            game_sel,
	input  wire                           swap,
	input  wire  [game_pkg::PLAYER_W-1:0] p1,
	input  wire  [game_pkg::PLAYER_W-1:0] p2,
	input  wire                           coin1,
	input  wire                           coin2,
	input  wire                           start1,
	input  wire                           start2,
	input  wire                           core_reset,
	output logic [game_pkg::JOY_W-1:0]    ja,
	output logic [game_pkg::JOY_W-1:0]    jb,
	output logic [game_pkg::BTN_W-1:0]    btn
);

	logic [game_pkg::PLAYER_W-1:0] q1;
	logic [game_pkg::PLAYER_W-1:0] q2;
	logic                          any_h;
	logic                          any_v;
	logic                          sin_x;
	logic                          sin_y;
	logic [game_pkg::JOY_W-1:0]    sin_word;

	// {right, left, down, up} as the core reads them
	function automatic logic [3:0] dirs(input logic [game_pkg::PLAYER_W-1:0] p);
		return {p[game_pkg::P_RIGHT], p[game_pkg::P_LEFT],
			p[game_pkg::P_DOWN], p[game_pkg::P_UP]};
	endfunction

	assign q1 = swap ? p2 : p1;
	assign q2 = swap ? p1 : p2;

	assign any_h = q1[game_pkg::P_RIGHT] | q1[game_pkg::P_LEFT] |
		q2[game_pkg::P_RIGHT] | q2[game_pkg::P_LEFT];
	assign any_v = q1[game_pkg::P_UP] | q1[game_pkg::P_DOWN] |
		q2[game_pkg::P_UP] | q2[game_pkg::P_DOWN];

	// Sinistar direction latches, right/up win over left/down
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sin_x <= 1'b0;
			sin_y <= 1'b0;
		end else begin
			if (q1[game_pkg::P_RIGHT] | q2[game_pkg::P_RIGHT])
				sin_x <= 1'b0;
			else if (q1[game_pkg::P_LEFT] | q2[game_pkg::P_LEFT])
				sin_x <= 1'b1;
			if (q1[game_pkg::P_UP] | q2[game_pkg::P_UP])
				sin_y <= 1'b0;
			else if (q1[game_pkg::P_DOWN] | q2[game_pkg::P_DOWN])
				sin_y <= 1'b1;
		end
	end

	assign sin_word = {sin_x, 2'b00, any_h, sin_y, 2'b00, any_v};

	always_comb begin
		btn = '0;
		btn[game_pkg::BTN_RESET] = core_reset;
		btn[game_pkg::BTN_COIN]  = coin1 | coin2;
		case (game_sel)
			game_pkg::JOUST: begin
				btn[game_pkg::BTN_START_HI] = start2;
				btn[game_pkg::BTN_START_LO] = start1;
				ja = ~{5'b00000, q1[game_pkg::P_FIRE_A], q1[game_pkg::P_RIGHT],
					q1[game_pkg::P_LEFT]};
				jb = ~{5'b00000, q2[game_pkg::P_FIRE_A], q2[game_pkg::P_RIGHT],
					q2[game_pkg::P_LEFT]};
			end
			game_pkg::SINISTAR: begin
				btn[game_pkg::BTN_START_HI] = start2;
				btn[game_pkg::BTN_START_LO] = start1;
				ja = sin_word;
				jb = sin_word;
			end
			default: begin
				// Robotron: both sticks on both ports
				btn[game_pkg::BTN_START_HI] = start1;
				btn[game_pkg::BTN_START_LO] = start2;
				ja = ~{dirs(q2), dirs(q1)};
				jb = ~{dirs(q2), dirs(q1)};
			end
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/game_pkg.sv
// Game layout select and player control encodings
// Player vector bit positions, joystick and button word sizes
`default_nettype none

package game_pkg;

	// Run-time game layout
	typedef enum logic [1:0] {
		ROBOTRON = 2'd0,
		JOUST    = 2'd1,
		SINISTAR = 2'd2
	} game_kind;

	// Player vector, one bit per control, active high
	localparam int P_RIGHT  = 0;
	localparam int P_LEFT   = 1;
	localparam int P_DOWN   = 2;
	localparam int P_UP     = 3;
	localparam int P_FIRE_A = 4;
	localparam int P_FIRE_B = 5;
	localparam int PLAYER_W = 6;

	// Button word as seen by the game core
	localparam int BTN_RESET    = 0;
	localparam int BTN_COIN     = 1;
	localparam int BTN_START_LO = 2;
	localparam int BTN_START_HI = 3;
	localparam int BTN_W        = 4;

	// Joystick word width for ja and jb
	localparam int JOY_W = 8;

endpackage

`default_nettype wire

//--- rtl/mem_pkg.sv
// ROM image layout for the main and sound CPUs
// Region bases, remap offset, address widths and gap fill byte
`default_nettype none

package mem_pkg;

	// Packed image: 0000-BFFF main, C000-CFFF sound
	localparam int ROM_AW = 16;
	localparam int SND_AW = 12;

	// Main CPU 0000-8FFF maps straight through
	localparam logic [15:0] MAIN_DIRECT_TOP = 16'h9000;

	// Main CPU D000-FFFF lands on image 9000-BFFF
	localparam logic [15:0] MAIN_HIGH_BASE    = 16'hD000;
	localparam logic [15:0] MAIN_REMAP_OFFSET = 16'h4000;

	// Sound CPU window
	localparam logic [15:0] SND_BASE = 16'hC000;

	// Read value for main addresses between the two regions
	localparam logic [7:0] UNMAPPED_BYTE = 8'hFF;

endpackage

`default_nettype wire

//--- rtl/reset_hold_timer.sv
// Post-load reset hold counter
// Pulses hold_done RESET_HOLD cycles after hold_start
`default_nettype none

module reset_hold_timer #(
	parameter int RESET_HOLD = 16
) (
	input  wire  clk_sys,
	input  wire  reset,
	input  wire  hold_start,
	output logic hold_done
);

	localparam int CW = (RESET_HOLD > 1) ? $clog2(RESET_HOLD) : 1;
	localparam logic [CW-1:0] LOAD_VAL = (RESET_HOLD > 0) ? CW'(RESET_HOLD - 1) : '0;

	logic [CW-1:0] count;
	logic          busy;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			busy  <= 1'b0;
			count <= '0;
		end else if (hold_start) begin
			// A new start always restarts the count
			busy  <= 1'b1;
			count <= LOAD_VAL;
		end else if (busy) begin
			if (count == '0)
				busy <= 1'b0;
			else
				count <= count - 1'b1;
		end
	end

	assign hold_done = busy && (count == '0);

endmodule

`default_nettype wire

//--- rtl/rom_download_fsm.sv
// Download tracking FSM
// Sets loaded after the first download and sequences core reset
`default_nettype none

module rom_download_fsm #(
	parameter int RESET_HOLD = 16
) (
	input  wire  clk_sys,
	input  wire  reset,
	input  wire  dl_active,
	input  wire  user_reset,
	input  wire  hold_done,
	output logic hold_start,
	output logic core_reset,
	output logic loaded
);

	typedef enum logic [1:0] {
		WAIT_LOAD = 2'd0,
		LOADING   = 2'd1,
		HOLD      = 2'd2,
		RUN       = 2'd3
	} state_t;

	state_t state;
	state_t state_next;
	logic   load_done;
	logic   rearm;

	assign load_done = (state == LOADING) && !dl_active;
	// User reset restarts the hold count from HOLD or RUN
	assign rearm = user_reset && !dl_active && (state == HOLD || state == RUN);

	always_comb begin
		state_next = state;
		if (dl_active) begin
			state_next = LOADING;
		end else begin
			case (state)
				WAIT_LOAD: state_next = WAIT_LOAD;
				LOADING:   state_next = (RESET_HOLD == 0) ? RUN : HOLD;
				HOLD:      state_next = (hold_done && !user_reset) ? RUN : HOLD;
				RUN:       state_next = user_reset ? HOLD : RUN;
				default:   state_next = WAIT_LOAD;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state      <= WAIT_LOAD;
			hold_start <= 1'b0;
			loaded     <= 1'b0;
		end else begin
			state      <= state_next;
			hold_start <= load_done || rearm;
			if (load_done)
				loaded <= 1'b1;
		end
	end

	// Core runs only in RUN
	assign core_reset = (state != RUN);

endmodule

`default_nettype wire

//--- rtl/rom_store.sv
// Byte ROM store loaded by the download stream
// Registered read ports for main CPU (with remap) and sound CPU
`default_nettype none

module rom_store #(
	parameter int ROM_AW = mem_pkg::ROM_AW
) (
	input  wire                        clk_sys,
	input  wire                        dl_wr,
	input  wire  [ROM_AW-1:0]          dl_addr,
	input  wire  [7:0]                 dl_data,
	input  wire  [ROM_AW-1:0]          main_addr,
	input  wire  [mem_pkg::SND_AW-1:0] snd_addr,
	output logic [7:0]                 main_data,
	output logic [7:0]                 snd_data
);

	localparam logic [ROM_AW-1:0] DIRECT_TOP   = ROM_AW'(mem_pkg::MAIN_DIRECT_TOP);
	localparam logic [ROM_AW-1:0] HIGH_BASE    = ROM_AW'(mem_pkg::MAIN_HIGH_BASE);
	localparam logic [ROM_AW-1:0] REMAP_OFFSET = ROM_AW'(mem_pkg::MAIN_REMAP_OFFSET);
	localparam logic [ROM_AW-1:0] SND_OFFSET   = ROM_AW'(mem_pkg::SND_BASE);

	logic [7:0]        mem [0:(2**ROM_AW)-1];
	logic [ROM_AW-1:0] main_idx;
	logic [ROM_AW-1:0] snd_idx;
	logic              main_gap;

	// D000-FFFF folds down onto 9000-BFFF
	always_comb begin
		main_gap = 1'b0;
		main_idx = main_addr;
		if (main_addr >= HIGH_BASE)
			main_idx = main_addr - REMAP_OFFSET;
		else if (main_addr >= DIRECT_TOP)
			main_gap = 1'b1;
	end

	assign snd_idx = SND_OFFSET + ROM_AW'(snd_addr);

	always_ff @(posedge clk_sys) begin
		if (dl_wr)
			mem[dl_addr] <= dl_data;
	end

	always_ff @(posedge clk_sys) begin
		main_data <= main_gap ? mem_pkg::UNMAPPED_BYTE : mem[main_idx];
		snd_data  <= mem[snd_idx];
	end

endmodule

`default_nettype wire

//--- verification/arcade_board_asserts.sv
// Bound assertions for the arcade board top level
// Core reset sequencing and per-game control word mapping
`default_nettype none

module arcade_board_asserts #(
	parameter int RESET_HOLD = 16
) (
	input wire                           clk_sys,
	input wire                           reset,
	input wire                           dl_active,
	input wire                           user_reset,
	input wire                           core_reset,
	input wire                           loaded,
	input game_pkg::game_kind            game_sel,
	input wire                           swap,
	input wire [game_pkg::PLAYER_W-1:0]  p1,
	input wire [game_pkg::PLAYER_W-1:0]  p2,
	input wire                           coin1,
	input wire                           coin2,
	input wire                           start1,
	input wire                           start2,
	input wire [game_pkg::JOY_W-1:0]     ja,
	input wire [game_pkg::JOY_W-1:0]     jb,
	input wire [game_pkg::BTN_W-1:0]     btn
);
	timeunit 1ns;
	timeprecision 100ps;

	int                            fail_count = 0;
	logic [game_pkg::PLAYER_W-1:0] q1;
	logic [game_pkg::PLAYER_W-1:0] q2;
	logic [game_pkg::PLAYER_W-1:0] any;
	logic                          sin;
	logic [7:0]                    exp_ja;
	logic [7:0]                    exp_jb;
	logic [7:0]                    jmask;
	logic [3:0]                    exp_btn;

	task automatic flag_error(input string msg);
		fail_count++;
		$error("%s", msg);
	endtask

	assign q1  = swap ? p2 : p1;
	assign q2  = swap ? p1 : p2;
	assign any = p1 | p2;
	assign sin = (game_sel == game_pkg::SINISTAR);

	always_comb begin
		exp_btn = {start2, start1, coin1 | coin2, core_reset};
		jmask   = 8'hFF;
		case (game_sel)
			game_pkg::ROBOTRON: begin
				exp_btn = {start1, start2, coin1 | coin2, core_reset};
				exp_ja  = ~{q2[game_pkg::P_RIGHT], q2[game_pkg::P_LEFT],
					q2[game_pkg::P_DOWN], q2[game_pkg::P_UP],
					q1[game_pkg::P_RIGHT], q1[game_pkg::P_LEFT],
					q1[game_pkg::P_DOWN], q1[game_pkg::P_UP]};
				exp_jb  = exp_ja;
			end
			game_pkg::JOUST: begin
				exp_ja = {5'b11111, ~q1[game_pkg::P_FIRE_A], ~q1[game_pkg::P_RIGHT],
					~q1[game_pkg::P_LEFT]};
				exp_jb = {5'b11111, ~q2[game_pkg::P_FIRE_A], ~q2[game_pkg::P_RIGHT],
					~q2[game_pkg::P_LEFT]};
			end
			default: begin
				// Latch bits 7 and 3 are checked one edge after a press
				jmask  = 8'b0111_0111;
				exp_ja = {3'b000, any[game_pkg::P_RIGHT] | any[game_pkg::P_LEFT],
					3'b000, any[game_pkg::P_UP] | any[game_pkg::P_DOWN]};
				exp_jb = exp_ja;
			end
		endcase
	end

	a_held_while_loading: assert property (@(posedge clk_sys) disable iff (reset)
		(!loaded || $past(dl_active)) |-> core_reset)
		else flag_error("core reset low before the download completed");

	a_hold_length: assert property (@(posedge clk_sys) disable iff (reset)
		$fell(dl_active) |-> ##(RESET_HOLD + 1) core_reset ##1 !core_reset)
		else flag_error("core reset hold after download has the wrong length");

	a_user_reset: assert property (@(posedge clk_sys) disable iff (reset)
		(!core_reset && user_reset) |=> core_reset)
		else flag_error("user reset did not put the core back into reset");

	a_control_map: assert property (@(posedge clk_sys) disable iff (reset)
		((ja & jmask) == exp_ja) && ((jb & jmask) == exp_jb) && (btn == exp_btn))
		else flag_error("joystick or button word does not match the game layout");

	a_sin_horizontal: assert property (@(posedge clk_sys) disable iff (reset)
		sin && (any[game_pkg::P_LEFT] || any[game_pkg::P_RIGHT]) |=> !sin ||
		(ja[7] == $past(!any[game_pkg::P_RIGHT]) && jb[7] == ja[7]))
		else flag_error("Sinistar horizontal latch did not follow left and right");

	a_sin_vertical: assert property (@(posedge clk_sys) disable iff (reset)
		sin && (any[game_pkg::P_DOWN] || any[game_pkg::P_UP]) |=> !sin ||
		(ja[3] == $past(!any[game_pkg::P_UP]) && jb[3] == ja[3]))
		else flag_error("Sinistar vertical latch did not follow down and up");

endmodule

bind arcade_board_top arcade_board_asserts #(.RESET_HOLD(RESET_HOLD)) u_asserts (.*);

`default_nettype wire

//--- verification/arcade_board_tb.sv
// Testbench for the arcade board glue
// Xorshift ROM download, read-back compares and control stimulus
`default_nettype none

module arcade_board_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int RESET_HOLD = 16;

	logic                          clk_sys;
	logic                          reset;
	logic                          dl_active;
	logic                          dl_wr;
	logic [15:0]                   dl_addr;
	logic [7:0]                    dl_data;
	logic                          user_reset;
	logic [15:0]                   main_addr;
	logic [11:0]                   snd_addr;
	game_pkg::game_kind            game_sel;
	logic                          swap;
	logic [game_pkg::PLAYER_W-1:0] p1;
	logic [game_pkg::PLAYER_W-1:0] p2;
	logic                          coin1;
	logic                          coin2;
	logic                          start1;
	logic                          start2;
	logic                          core_reset;
	logic                          loaded;
	logic [7:0]                    main_data;
	logic [7:0]                    snd_data;
	logic [game_pkg::JOY_W-1:0]    ja;
	logic [game_pkg::JOY_W-1:0]    jb;
	logic [game_pkg::BTN_W-1:0]    btn;

	logic [7:0]  image [0:65535];
	logic [31:0] rng;
	int          errors;

	arcade_board_top #(.RESET_HOLD(RESET_HOLD)) uut (.*);

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	task automatic check_byte(input string name, input logic [15:0] addr,
		input logic [7:0] expected, input logic [7:0] actual);
		if (actual !== expected) begin
			errors++;
			$display("CHECK FAILED %s addr %h: expected %h, actual %h",
				name, addr, expected, actual);
		end
	endtask

	task automatic compare_flag(input string name, input logic expected,
		input logic actual);
		if (actual !== expected) begin
			errors++;
			$display("CHECK FAILED %s: expected %b, actual %b",
				name, expected, actual);
		end
	endtask

	// Bounded wait for the core to leave reset
	task automatic wait_core_run(input string phase);
		int cycles;
		cycles = 0;
		while (core_reset && cycles < 200) begin
			@(posedge clk_sys);
			#1;
			cycles++;
		end
		if (core_reset) begin
			errors++;
			$display("Timeout: core reset was not released %s", phase);
		end
	endtask

	task automatic drive_players(input logic [5:0] a, input logic [5:0] b);
		@(posedge clk_sys);
		#1;
		p1 = a;
		p2 = b;
	endtask

	task automatic random_controls(input int cycles);
		repeat (cycles) begin
			rng = xorshift(rng);
			drive_players(rng[5:0], rng[11:6]);
			{start2, start1, coin2, coin1} = rng[15:12];
			swap = rng[16];
		end
	endtask

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	initial begin
		logic [15:0] addr;
		logic [7:0]  expected;
		reset = 1'b1;
		{dl_active, dl_wr, dl_addr, dl_data, user_reset, main_addr, snd_addr} = '0;
		{swap, p1, p2, coin1, coin2, start1, start2} = '0;
		game_sel = game_pkg::ROBOTRON;
		errors   = 0;
		rng      = 32'h30b728b0;
		repeat (10) @(posedge clk_sys);
		#1 reset = 1'b0;

		// Image 0000-CFFF, one byte per cycle
		dl_active = 1'b1;
		for (int a = 0; a < 'hD000; a++) begin
			@(posedge clk_sys);
			#1;
			rng      = xorshift(rng);
			image[a] = rng[7:0];
			dl_wr    = 1'b1;
			dl_addr  = 16'(a);
			dl_data  = rng[7:0];
		end
		@(posedge clk_sys);
		#1;
		compare_flag("loaded during download", 1'b0, loaded);
		dl_wr     = 1'b0;
		dl_active = 1'b0;
		wait_core_run("after the download");
		compare_flag("loaded after download", 1'b1, loaded);

		for (int a = 0; a < 'h10000; a++) begin
			addr      = 16'(a);
			main_addr = addr;
			@(posedge clk_sys);
			#1;
			if (addr < mem_pkg::MAIN_DIRECT_TOP)
				expected = image[addr];
			else if (addr >= mem_pkg::MAIN_HIGH_BASE)
				expected = image[addr - mem_pkg::MAIN_REMAP_OFFSET];
			else
				expected = mem_pkg::UNMAPPED_BYTE;
			check_byte("main read", addr, expected, main_data);
		end
		for (int a = 0; a < 'h1000; a++) begin
			snd_addr = 12'(a);
			@(posedge clk_sys);
			#1;
			check_byte("sound read", 16'(a), image[mem_pkg::SND_BASE + 16'(a)], snd_data);
		end

		user_reset = 1'b1;
		@(posedge clk_sys);
		#1 user_reset = 1'b0;
		wait_core_run("after user reset");
		compare_flag("loaded after user reset", 1'b1, loaded);

		game_sel = game_pkg::ROBOTRON;
		random_controls(200);
		game_sel = game_pkg::JOUST;
		random_controls(200);
		// Sinistar latches: left then right, down then up
		game_sel = game_pkg::SINISTAR;
		drive_players(6'(1) << game_pkg::P_LEFT, '0);
		drive_players('0, 6'(1) << game_pkg::P_RIGHT);
		drive_players(6'(1) << game_pkg::P_DOWN, '0);
		drive_players('0, 6'(1) << game_pkg::P_UP);
		random_controls(200);
		drive_players('0, '0);

		@(posedge clk_sys);
		#1;
		$display("Errors: %0d compare, %0d assertion", errors, uut.u_asserts.fail_count);
		if (errors == 0 && uut.u_asserts.fail_count == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire
